// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module farm_monitor_tb \
	  -f farm_monitor_top.f -o farm_monitor_sim
	./obj_dir/farm_monitor_sim > $(LOG) 2>&1 || echo "sim failed" >> $(LOG)
	cat $(LOG)
	! grep -q "sim failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/farm_link_pkg.sv ====
// Serial link format shared by the UART blocks and the packet parser; referenced by scoped name
package farm_link_pkg;

  // ==============================
  // Byte and packet framing
  // ==============================
  typedef logic [7:0] byte_t;                // One UART data byte

  localparam byte_t pkt_header = 8'hAA;      // Start of every packet
  localparam int pkt_payload_len = 6;        // Temp, humidity, light, soil, faults, actuator
  localparam byte_t ack_byte = 8'h55;        // Returned once per accepted packet

  // Parser position within a packet, in wire order
  typedef enum logic [2:0] {
    fld_header   = 3'd0,
    fld_temp     = 3'd1,
    fld_humidity = 3'd2,
    fld_light    = 3'd3,
    fld_soil     = 3'd4,
    fld_faults   = 3'd5,
    fld_actuator = 3'd6,                     // Checksum only, never stored
    fld_checksum = 3'd7
  } pkt_field_t;

endpackage

// ==== design/farm_monitor_top.sv ====
// Field monitor top level; connects the UART receiver, packet parser, decision block and ACK sender
`timescale 1ns/1ps

module farm_monitor_top #(
  parameter int clks_per_bit = 868   // 100 MHz at 115200 baud
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  rx,
  output logic                                  tx,
  output logic                                  harvest_alert,
  output farm_status_pkg::alert_t               alert_level,
  output logic                                  fault_detected,
  output logic [farm_status_pkg::led_count-1:0] status_leds
);

  farm_link_pkg::byte_t           rx_byte;
  logic                           rx_valid;
  farm_status_pkg::sensor_level_t temp, humidity, light, soil;
  farm_status_pkg::fault_t        faults;
  logic                           pkt_ok;
  logic                           pkt_err;

  // ==============================
  // Receive path
  // ==============================
  uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
    .clk(clk), .rst_n(rst_n), .rx(rx),
    .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  sensor_packet_parser u_parser (
    .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .temp(temp), .humidity(humidity), .light(light), .soil(soil),
    .faults(faults), .pkt_ok(pkt_ok), .pkt_err(pkt_err)
  );

  harvest_decision u_decision (
    .clk(clk), .rst_n(rst_n),
    .temp(temp), .humidity(humidity), .light(light), .soil(soil),
    .faults(faults), .pkt_ok(pkt_ok), .pkt_err(pkt_err),
    .harvest_alert(harvest_alert), .alert_level(alert_level),
    .fault_detected(fault_detected), .status_leds(status_leds)
  );

  // ACK per good packet
  uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (
    .clk(clk), .rst_n(rst_n), .start(pkt_ok), .tx(tx)
  );

endmodule

// ==== design/farm_status_pkg.sv ====
// Farm status encodings for the decision logic and the testbench; referenced by scoped name
package farm_status_pkg;

  // ==============================
  // Sensor and fault values
  // ==============================
  typedef logic [1:0] sensor_level_t;        // Low two bits of a payload byte
  localparam sensor_level_t sensor_optimal = 2'd2;

  typedef logic [7:0] fault_t;               // One flag per fault source

  // ==============================
  // Alert levels and LEDs
  // ==============================
  typedef enum logic [2:0] {
    alert_idle       = 3'd0,                 // No packet seen yet
    alert_suboptimal = 3'd2,
    alert_harvest    = 3'd6,
    alert_critical   = 3'd7                  // Any fault flag set
  } alert_t;

  localparam int led_count = 4;

  localparam int led_optimal = 0;            // All sensors optimal
  localparam int led_fault   = 1;            // Any fault
  localparam int led_pkt_ok  = 2;            // Good packet pulse
  localparam int led_pkt_err = 3;            // Bad checksum pulse

endpackage

// ==== design/harvest_decision.sv ====
// Harvest decision; registers the alert level, harvest flag, fault flag and status LEDs
`timescale 1ns/1ps

module harvest_decision (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  farm_status_pkg::sensor_level_t       temp,
  input  farm_status_pkg::sensor_level_t       humidity,
  input  farm_status_pkg::sensor_level_t       light,
  input  farm_status_pkg::sensor_level_t       soil,
  input  farm_status_pkg::fault_t              faults,
  input  logic                                 pkt_ok,
  input  logic                                 pkt_err,
  output logic                                 harvest_alert,
  output farm_status_pkg::alert_t              alert_level,
  output logic                                 fault_detected,
  output logic [farm_status_pkg::led_count-1:0] status_leds
);

  logic data_seen;               // Set by first good packet
  logic all_optimal;
  logic any_fault;
  logic ok_led;
  logic err_led;

  assign all_optimal = (temp     == farm_status_pkg::sensor_optimal) &&
                       (humidity == farm_status_pkg::sensor_optimal) &&
                       (light    == farm_status_pkg::sensor_optimal) &&
                       (soil     == farm_status_pkg::sensor_optimal);
  assign any_fault   = |faults;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_seen      <= 1'b0;
      harvest_alert  <= 1'b0;
      fault_detected <= 1'b0;
      alert_level    <= farm_status_pkg::alert_idle;
      ok_led         <= 1'b0;
      err_led        <= 1'b0;
    end else begin
      if (pkt_ok) data_seen <= 1'b1;
      harvest_alert  <= all_optimal;
      fault_detected <= any_fault;
      ok_led         <= pkt_ok;   // One-cycle blink
      err_led        <= pkt_err;
      // Priority: fault, then harvest, then suboptimal
      if (!(data_seen || pkt_ok)) alert_level <= farm_status_pkg::alert_idle;
      else if (any_fault)         alert_level <= farm_status_pkg::alert_critical;
      else if (all_optimal)       alert_level <= farm_status_pkg::alert_harvest;
      else                        alert_level <= farm_status_pkg::alert_suboptimal;
    end
  end

  // LED map
  assign status_leds[farm_status_pkg::led_optimal] = harvest_alert;
  assign status_leds[farm_status_pkg::led_fault]   = fault_detected;
  assign status_leds[farm_status_pkg::led_pkt_ok]  = ok_led;
  assign status_leds[farm_status_pkg::led_pkt_err] = err_led;

endmodule

// ==== design/sensor_packet_parser.sv ====
// Sensor packet framer; checks the checksum and holds the latest accepted sensor values
`timescale 1ns/1ps

module sensor_packet_parser (
  input  logic                           clk,
  input  logic                           rst_n,
  input  farm_link_pkg::byte_t           rx_byte,
  input  logic                           rx_valid,
  output farm_status_pkg::sensor_level_t temp,
  output farm_status_pkg::sensor_level_t humidity,
  output farm_status_pkg::sensor_level_t light,
  output farm_status_pkg::sensor_level_t soil,
  output farm_status_pkg::fault_t        faults,
  output logic                           pkt_ok,
  output logic                           pkt_err
);

  localparam int shadow_len = farm_link_pkg::pkt_payload_len - 1;  // Actuator byte not kept

  farm_link_pkg::pkt_field_t field;                  // Position of the next byte
  farm_link_pkg::byte_t      csum;                   // Running payload sum
  farm_link_pkg::byte_t      shadow [shadow_len];    // Payload of the packet in flight
  logic                      keep_byte;
  logic                      sum_match;

  assign keep_byte = (field >= farm_link_pkg::fld_temp) && (field <= farm_link_pkg::fld_faults);
  assign sum_match = (rx_byte == csum);

  // ==============================
  // Framing and commit
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      field    <= farm_link_pkg::fld_header;
      csum     <= '0;
      pkt_ok   <= 1'b0;
      pkt_err  <= 1'b0;
      temp     <= '0;
      humidity <= '0;
      light    <= '0;
      soil     <= '0;
      faults   <= '0;
    end else begin
      pkt_ok  <= 1'b0;           // Pulses by default
      pkt_err <= 1'b0;
      if (rx_valid) begin
        case (field)
          farm_link_pkg::fld_header: begin
            if (rx_byte == farm_link_pkg::pkt_header) begin  // Stray bytes dropped
              csum  <= '0;
              field <= farm_link_pkg::fld_temp;
            end
          end
          farm_link_pkg::fld_checksum: begin
            field <= farm_link_pkg::fld_header;
            if (sum_match) begin
              temp     <= shadow[0][1:0];
              humidity <= shadow[1][1:0];
              light    <= shadow[2][1:0];
              soil     <= shadow[3][1:0];
              faults   <= shadow[4];
              pkt_ok   <= 1'b1;
            end else begin
              pkt_err  <= 1'b1;  // Outputs keep the last good packet
            end
          end
          default: begin         // Payload bytes, actuator included
            csum  <= csum + rx_byte;
            field <= farm_link_pkg::pkt_field_t'(field + 3'd1);
          end
        endcase
      end
    end
  end

  // Shadow capture, slot = payload position
  always_ff @(posedge clk) begin
    if (rx_valid && keep_byte) shadow[3'(field) - 3'd1] <= rx_byte;
  end

endmodule

// ==== design/uart_rx.sv ====
// UART receiver, 8N1; turns the serial line into one-cycle byte pulses for the packet parser
`timescale 1ns/1ps

module uart_rx #(
  parameter int clks_per_bit = 868
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output farm_link_pkg::byte_t rx_byte,
  output logic                 rx_valid
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] bit_half = cnt_w'((clks_per_bit - 1) / 2);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

  state_t               state;
  logic [cnt_w-1:0]     clk_count;
  logic [2:0]           bit_idx;
  logic                 rx_meta;   // First sync stage
  logic                 rx_s;      // Synchronized line
  farm_link_pkg::byte_t shift;     // Bits collected so far, LSB first
  logic                 sample_bit;
  logic                 stop_ok;

  // ==============================
  // Line synchronizer
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;             // Line idles high
      rx_s    <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
    end
  end

  assign sample_bit = (state == st_data) && (clk_count == bit_last);          // Bit centre
  assign stop_ok    = (state == st_stop) && (clk_count == bit_last) && rx_s;  // Framing good

  // ==============================
  // Bit timing FSM
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      clk_count <= '0;
      bit_idx   <= '0;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= stop_ok;         // Single-cycle pulse
      case (state)
        st_idle: begin
          clk_count <= '0;
          bit_idx   <= '0;
          if (!rx_s) state <= st_start;  // Falling edge of start bit
        end
        st_start: begin
          if (clk_count == bit_half) begin
            clk_count <= '0;
            state     <= rx_s ? st_idle : st_data;  // Glitch rejected here
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        st_data: begin
          if (sample_bit) begin
            clk_count <= '0;
            bit_idx   <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) state <= st_stop;
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        st_stop: begin
          if (clk_count == bit_last) begin
            clk_count <= '0;
            state     <= st_idle;   // Low stop bit just drops the byte
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    if (sample_bit) shift <= {rx_s, shift[7:1]};  // LSB arrives first
    if (stop_ok) rx_byte <= shift;
  end

endmodule

// ==== design/uart_tx.sv ====
// UART transmitter, 8N1; sends the fixed acknowledge byte each time start is seen while idle
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = 868
) (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic tx
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

  state_t           state;
  logic [cnt_w-1:0] clk_count;
  logic [2:0]       bit_idx;
  logic             bit_done;

  assign bit_done = (clk_count == bit_last);  // End of current bit time

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      clk_count <= '0;
      bit_idx   <= '0;
      tx        <= 1'b1;         // Idle high
    end else begin
      case (state)
        st_idle: begin
          clk_count <= '0;
          bit_idx   <= '0;
          tx        <= 1'b1;
          if (start) begin
            tx    <= 1'b0;       // Start bit on the very next cycle
            state <= st_start;
          end
        end
        st_start: begin
          if (bit_done) begin
            clk_count <= '0;
            tx        <= farm_link_pkg::ack_byte[0];
            state     <= st_data;
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        st_data: begin
          if (bit_done) begin
            clk_count <= '0;
            if (bit_idx == 3'd7) begin
              tx    <= 1'b1;     // Stop bit
              state <= st_stop;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              tx      <= farm_link_pkg::ack_byte[bit_idx + 3'd1];
            end
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        st_stop: begin
          if (bit_done) begin
            clk_count <= '0;
            state     <= st_idle;  // Starts during a frame are dropped
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== dv/farm_monitor_chk.sv ====
// Bound assertions for packet pulses, alert encoding and the idle tx level; bound into two blocks
`timescale 1ns/1ps

module farm_monitor_chk #(
  parameter bit tx_side = 1'b0                // Set on the uart_tx bind only
) (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    pkt_ok,
  input logic                    pkt_err,
  input farm_status_pkg::alert_t alert_level,
  input logic                    tx,
  input logic [1:0]              tx_state     // Encoding 0 is the idle state
);

  if (!tx_side) begin : g_decision
    // Good and bad packet never in the same cycle
    a_pkt_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(pkt_ok && pkt_err))
      else $error("pkt_ok and pkt_err are high in the same cycle");

    // Only the four defined alert codes
    a_alert_legal: assert property (@(posedge clk) disable iff (!rst_n)
      alert_level inside {farm_status_pkg::alert_idle, farm_status_pkg::alert_suboptimal,
                          farm_status_pkg::alert_harvest, farm_status_pkg::alert_critical})
      else $error("alert_level holds an undefined code");
  end else begin : g_tx
    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_state == 2'd0) |-> tx)
      else $error("tx is low while no frame is in progress");  // Line must idle high
  end

endmodule

// ==============================
// Bind points
// ==============================
bind harvest_decision farm_monitor_chk #(.tx_side(1'b0)) u_decision_chk (
  .clk(clk), .rst_n(rst_n), .pkt_ok(pkt_ok), .pkt_err(pkt_err),
  .alert_level(alert_level), .tx(1'b1), .tx_state(2'd0)
);

bind uart_tx farm_monitor_chk #(.tx_side(1'b1)) u_tx_chk (
  .clk(clk), .rst_n(rst_n), .pkt_ok(start), .pkt_err(1'b0),
  .alert_level(farm_status_pkg::alert_idle), .tx(tx), .tx_state(state)
);

// ==== dv/farm_monitor_stim.txt ====
// n_stray stray_byte, then header temp humidity light soil faults actuator checksum
// then expected harvest_alert, alert_level code, fault_detected, acknowledge sent
00 3C  AA 12 06 FE 02 00 30 48  01 06 00 01
00 3C  AA 01 02 02 02 00 00 07  00 02 00 01
00 3C  AA 02 02 02 02 04 00 0C  01 07 01 01
00 3C  AA 02 02 02 02 00 00 09  01 07 01 00
02 3C  AA 03 02 02 02 00 11 1A  00 02 00 01
00 3C  AA 02 02 02 02 00 00 08  01 06 00 01
00 3C  AA 00 01 03 02 81 A5 2C  00 07 01 01
00 3C  AA 02 02 02 02 00 00 FF  00 07 01 00

// ==== dv/farm_monitor_tb.sv ====
// Field monitor testbench; replays packets from the stimulus file and checks outputs and ACK frames
`timescale 1ns/1ps

module farm_monitor_tb;

  localparam int clks_per_bit = 16;
  localparam int cols         = 14;             // Tokens per stimulus line
  localparam int num_cases    = 8;
  localparam int col_n_stray  = 0;
  localparam int col_stray    = 1;
  localparam int col_pkt      = 2;              // Header, payload, checksum
  localparam int col_harvest  = 10;
  localparam int col_alert    = 11;
  localparam int col_fault    = 12;
  localparam int col_ack      = 13;
  localparam int pkt_bytes    = farm_link_pkg::pkt_payload_len + 2;
  localparam int ack_window   = 20 * clks_per_bit;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  rx;
  logic                                  tx;
  logic                                  harvest_alert;
  farm_status_pkg::alert_t               alert_level;
  logic                                  fault_detected;
  logic [farm_status_pkg::led_count-1:0] status_leds;

  farm_link_pkg::byte_t stim_mem [num_cases * cols];
  farm_link_pkg::byte_t ack_q [$];              // Decoded tx frames
  logic                 ack_busy = 1'b0;        // Frame being decoded
  int                   ok_pulses = 0;
  int                   err_pulses = 0;
  int                   value_errors = 0;
  int                   other_errors = 0;
  int                   case_id = 0;            // 0 is the reset check

  tb_clock_gen #(.period_ns(40), .reset_cycles(8)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  farm_monitor_top #(.clks_per_bit(clks_per_bit)) DUT (
    .clk(clk), .rst_n(rst_n), .rx(rx), .tx(tx),
    .harvest_alert(harvest_alert), .alert_level(alert_level),
    .fault_detected(fault_detected), .status_leds(status_leds)
  );

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_alert(input string what, input farm_status_pkg::alert_t got,
                             input farm_status_pkg::alert_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at time %0t: case %0d %s is %s, expected %s",
               $time, case_id, what, got.name(), exp.name());
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at time %0t: case %0d %s is %b, expected %b",
               $time, case_id, what, got, exp);
    end
  endtask

  task automatic check_byte(input string what, input farm_link_pkg::byte_t got,
                            input farm_link_pkg::byte_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at time %0t: case %0d %s is %h, expected %h",
               $time, case_id, what, got, exp);
    end
  endtask

  // ==============================
  // Serial drive, called on a falling edge
  // ==============================
  task automatic send_bit(input logic v);
    rx <= v;
    repeat (clks_per_bit) @(negedge clk);       // One bit time
  endtask

  task automatic send_byte(input farm_link_pkg::byte_t b);
    send_bit(1'b0);                             // Start
    for (int i = 0; i < 8; i++) send_bit(b[i]); // LSB first
    send_bit(1'b1);                             // Stop
  endtask

  // LED pulse counters, sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && status_leds[farm_status_pkg::led_pkt_ok]) ok_pulses++;
    if (rst_n && status_leds[farm_status_pkg::led_pkt_err]) err_pulses++;
  end

  // ACK decoder on tx
  initial begin : ack_monitor
    farm_link_pkg::byte_t data;
    forever begin
      @(negedge clk);
      if (rst_n && !tx) begin
        ack_busy = 1'b1;
        repeat (clks_per_bit / 2) @(negedge clk);  // Centre of start bit
        if (tx) begin
          other_errors++;
          $display("Start bit on tx ended before its centre");
        end
        for (int i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(negedge clk);
          data[i] = tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        if (!tx) begin
          other_errors++;
          $display("Acknowledge frame on tx has a low stop bit");
        end
        ack_q.push_back(data);
        ack_busy = 1'b0;
      end
    end
  end

  // ==============================
  // Per-case flow
  // ==============================
  task automatic wait_for_result(input int ok0, input int err0, output bit seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < 4 * clks_per_bit) begin
      @(posedge clk);
      cycles++;
      seen = (ok_pulses != ok0) || (err_pulses != err0);
    end
  endtask

  task automatic expect_ack();
    int                   cycles;
    farm_link_pkg::byte_t got;
    cycles = 0;
    while (ack_q.size() == 0 && cycles < ack_window) begin
      @(posedge clk);
      cycles++;
    end
    if (ack_q.size() == 0) begin
      other_errors++;
      $display("Case %0d: no acknowledge frame on tx within 20 bit times", case_id);
    end else begin
      got = ack_q.pop_front();
      check_byte("acknowledge byte", got, farm_link_pkg::ack_byte);
    end
  endtask

  task automatic expect_no_ack();
    int cycles;
    cycles = 0;
    while (cycles < ack_window) begin           // Full quiet window
      @(posedge clk);
      cycles++;
    end
    if (ack_q.size() != 0 || ack_busy) begin
      other_errors++;
      $display("Case %0d: acknowledge sent for a rejected packet", case_id);
      ack_q.delete();
    end
  endtask

  task automatic run_case(input int c);
    int                      base;
    int                      ok0;
    int                      err0;
    bit                      seen;
    logic                    exp_ack;
    farm_status_pkg::alert_t exp_alert;
    base      = c * cols;
    case_id   = c + 1;
    exp_ack   = stim_mem[base + col_ack][0];
    exp_alert = farm_status_pkg::alert_t'(stim_mem[base + col_alert][2:0]);
    ok0       = ok_pulses;
    err0      = err_pulses;
    @(negedge clk);
    for (int s = 0; s < int'(stim_mem[base + col_n_stray]); s++)
      send_byte(stim_mem[base + col_stray]);    // Noise ahead of the header
    for (int b = 0; b < pkt_bytes; b++) send_byte(stim_mem[base + col_pkt + b]);
    wait_for_result(ok0, err0, seen);
    if (!seen) begin
      other_errors++;
      $display("Case %0d: no packet ok or error pulse after the checksum byte", case_id);
    end
    @(negedge clk);
    check_flag("harvest_alert", harvest_alert, stim_mem[base + col_harvest][0]);
    check_alert("alert_level", alert_level, exp_alert);
    check_flag("fault_detected", fault_detected, stim_mem[base + col_fault][0]);
    check_flag("led_optimal", status_leds[farm_status_pkg::led_optimal],
               stim_mem[base + col_harvest][0]);
    check_flag("led_fault", status_leds[farm_status_pkg::led_fault],
               stim_mem[base + col_fault][0]);
    check_flag("led_pkt_ok pulse", ok_pulses != ok0, exp_ack);
    check_flag("led_pkt_err pulse", err_pulses != err0, !exp_ack);
    if (exp_ack) expect_ack();
    else expect_no_ack();
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin : main
    int cycles;
    rx = 1'b1;                                  // Line idle
    $readmemh("dv/farm_monitor_stim.txt", stim_mem);
    cycles = 0;
    while (!rst_n && cycles < 100) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      other_errors++;
      $display("Reset was never released");
    end
    @(negedge clk);
    check_flag("harvest_alert", harvest_alert, 1'b0);
    check_alert("alert_level", alert_level, farm_status_pkg::alert_idle);
    check_flag("fault_detected", fault_detected, 1'b0);
    for (int i = 0; i < farm_status_pkg::led_count; i++)
      check_flag("status_leds bit", status_leds[i], 1'b0);
    check_flag("tx", tx, 1'b1);
    for (int c = 0; c < num_cases; c++) run_case(c);
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset source; instantiated once by the field monitor testbench
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;                      // Held low from time zero
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;                      // Released away from the active edge
  end

endmodule

// ==== farm_monitor_top.f ====
design/farm_link_pkg.sv
design/farm_status_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/sensor_packet_parser.sv
design/harvest_decision.sv
design/farm_monitor_top.sv
dv/tb_clock_gen.sv
dv/farm_monitor_chk.sv
dv/farm_monitor_tb.sv
